//--- hw/vec_alu_consts.svh
`ifndef VEC_ALU_CONSTS_SVH
`define VEC_ALU_CONSTS_SVH

// datapath sizes
`define VEC_DATA_W       64
`define VEC_OPC_W        6

// lanes per 64-bit operand for each width code
`define VEC_BYTE_LANES   8
`define VEC_HALF_LANES   4
`define VEC_WORD_LANES   2
`define VEC_DOUBLE_LANES 1

// shift amount field, low bits of each b lane
`define VEC_SH_BYTE_W    3
`define VEC_SH_HALF_W    4
`define VEC_SH_WORD_W    5
`define VEC_SH_DOUBLE_W  6

// opcode values, 14/15/18 (div, mod, sqrt) and 19/21/22 left unused
`define VEC_OP_VAND      6'd1
`define VEC_OP_VOR       6'd2
`define VEC_OP_VXOR      6'd3
`define VEC_OP_VNOT      6'd4
`define VEC_OP_VMOV      6'd5
`define VEC_OP_VADD      6'd6
`define VEC_OP_VSUB      6'd7
`define VEC_OP_VMULEU    6'd8
`define VEC_OP_VMULOU    6'd9
`define VEC_OP_VSLL      6'd10
`define VEC_OP_VSRL      6'd11
`define VEC_OP_VSRA      6'd12
`define VEC_OP_VRTTH     6'd13
`define VEC_OP_VSQEU     6'd16
`define VEC_OP_VSQOU     6'd17
`define VEC_OP_VSD       6'd20
`define VEC_OP_VNOP      6'd23

`endif

//--- hw/vec_alu_pkg.sv
`include "vec_alu_consts.svh"

package vec_alu_pkg;

    // ************************************************************************
    // opcodes kept from the original vector ALU
    // ************************************************************************
    typedef enum logic [`VEC_OPC_W-1:0] {
        OP_VAND   = `VEC_OP_VAND,
        OP_VOR    = `VEC_OP_VOR,
        OP_VXOR   = `VEC_OP_VXOR,
        OP_VNOT   = `VEC_OP_VNOT,
        OP_VMOV   = `VEC_OP_VMOV,
        OP_VADD   = `VEC_OP_VADD,
        OP_VSUB   = `VEC_OP_VSUB,
        OP_VMULEU = `VEC_OP_VMULEU,
        OP_VMULOU = `VEC_OP_VMULOU,
        OP_VSLL   = `VEC_OP_VSLL,
        OP_VSRL   = `VEC_OP_VSRL,
        OP_VSRA   = `VEC_OP_VSRA,
        OP_VRTTH  = `VEC_OP_VRTTH,
        OP_VSQEU  = `VEC_OP_VSQEU,
        OP_VSQOU  = `VEC_OP_VSQOU,
        OP_VSD    = `VEC_OP_VSD,
        OP_VNOP   = `VEC_OP_VNOP
    } alu_op_t;

    // lane size, value doubles as index into per-width result tables
    typedef enum logic [1:0] {
        LW_BYTE   = 2'b00,
        LW_HALF   = 2'b01,
        LW_WORD   = 2'b10,
        LW_DOUBLE = 2'b11
    } lane_width_t;

    // lane 0 sits at the most significant end
    typedef logic [`VEC_DATA_W-1:0] vec_word_t;

    // one issued operation, 136 bits
    typedef struct packed {
        alu_op_t     op;
        lane_width_t width;
        vec_word_t   a;
        vec_word_t   b;
    } alu_req_t;

endpackage

//--- hw/lane_add_sub.sv
`include "vec_alu_consts.svh"

module lane_add_sub (
    input  vec_alu_pkg::alu_req_t  req,
    output vec_alu_pkg::vec_word_t sum
);

    // lanes per width code, indexed by lane_width_t
    localparam int LANES [4] = '{
        `VEC_BYTE_LANES,
        `VEC_HALF_LANES,
        `VEC_WORD_LANES,
        `VEC_DOUBLE_LANES
    };

    logic                   sub;              // a - b done as a + ~b + 1
    logic [`VEC_DATA_W-1:0] b_op;             // b or its complement
    logic [`VEC_DATA_W-1:0] lane_res [4];     // one full result per width

    assign sub  = (req.op == vec_alu_pkg::OP_VSUB);
    assign b_op = sub ? ~req.b : req.b;

    // ************************************************************************
    // separate adder per lane, the +1 of a subtract is fed into every lane
    // so no carry or borrow ever leaks into the neighbour
    // ************************************************************************
    for (genvar w = 0; w < 4; w++) begin : g_width
        localparam int LW = `VEC_DATA_W / LANES[w];

        for (genvar l = 0; l < LANES[w]; l++) begin : g_lane
            localparam int HI = `VEC_DATA_W - 1 - l * LW;   // lane 0 at top

            logic [LW-1:0] lane_a;
            logic [LW-1:0] lane_b;

            assign lane_a = req.a[HI -: LW];
            assign lane_b = b_op[HI -: LW];

            // wraps modulo 2**LW
            assign lane_res[w][HI -: LW] = lane_a + lane_b + LW'(sub);
        end
    end

    // width code picks the partition
    assign sum = lane_res[req.width];

endmodule

//--- hw/lane_shift_rotate.sv
`include "vec_alu_consts.svh"

module lane_shift_rotate (
    input  vec_alu_pkg::alu_req_t  req,
    output vec_alu_pkg::vec_word_t shifted
);

    localparam int LANES [4] = '{
        `VEC_BYTE_LANES,
        `VEC_HALF_LANES,
        `VEC_WORD_LANES,
        `VEC_DOUBLE_LANES
    };

    // shift field size, log2 of the lane width
    localparam int SHIFT_W [4] = '{
        `VEC_SH_BYTE_W,
        `VEC_SH_HALF_W,
        `VEC_SH_WORD_W,
        `VEC_SH_DOUBLE_W
    };

    logic [`VEC_DATA_W-1:0] sll_res [4];
    logic [`VEC_DATA_W-1:0] srl_res [4];
    logic [`VEC_DATA_W-1:0] sra_res [4];
    logic [`VEC_DATA_W-1:0] rot_res [4];

    // ************************************************************************
    // every lane of a is shifted by the low bits of the same lane of b
    // ************************************************************************
    for (genvar w = 0; w < 4; w++) begin : g_width
        localparam int LW = `VEC_DATA_W / LANES[w];
        localparam int SW = SHIFT_W[w];

        for (genvar l = 0; l < LANES[w]; l++) begin : g_lane
            localparam int HI = `VEC_DATA_W - 1 - l * LW;
            localparam int LO = HI - LW + 1;

            logic [LW-1:0] lane_a;
            logic [SW-1:0] amt;

            assign lane_a = req.a[HI -: LW];
            assign amt    = req.b[LO +: SW];    // lsbs of the b lane

            // bits shifted out of a lane are dropped, never passed on
            assign sll_res[w][HI -: LW] = lane_a << amt;
            assign srl_res[w][HI -: LW] = lane_a >> amt;

            // sign fill from the lane's own top bit
            assign sra_res[w][HI -: LW] = $signed(lane_a) >>> amt;

            // swap upper and lower half of the lane
            assign rot_res[w][HI -: LW] = {lane_a[LW/2-1:0], lane_a[LW-1:LW/2]};
        end
    end

    // ************************************************************************
    // pick shift kind, anything outside the shift class gives zero
    // ************************************************************************
    always_comb begin
        case (req.op)
            vec_alu_pkg::OP_VSLL: begin
                shifted = sll_res[req.width];
            end
            vec_alu_pkg::OP_VSRL: begin
                shifted = srl_res[req.width];
            end
            vec_alu_pkg::OP_VSRA: begin
                shifted = sra_res[req.width];
            end
            vec_alu_pkg::OP_VRTTH: begin
                shifted = rot_res[req.width];
            end
            default: begin
                shifted = '0;
            end
        endcase
    end

endmodule

//--- hw/lane_multiply.sv
`include "vec_alu_consts.svh"

module lane_multiply (
    input  vec_alu_pkg::alu_req_t  req,
    output vec_alu_pkg::vec_word_t product
);

    // only byte, half and word lanes can widen into 64 bits
    localparam int LANES [3] = '{
        `VEC_BYTE_LANES,
        `VEC_HALF_LANES,
        `VEC_WORD_LANES
    };

    logic                   odd;             // odd-numbered source lanes
    logic                   square;          // second factor is a again
    logic [`VEC_DATA_W-1:0] factor_b;
    logic [`VEC_DATA_W-1:0] prod_res [3];

    assign odd    = (req.op == vec_alu_pkg::OP_VMULOU) || (req.op == vec_alu_pkg::OP_VSQOU);
    assign square = (req.op == vec_alu_pkg::OP_VSQEU) || (req.op == vec_alu_pkg::OP_VSQOU);

    assign factor_b = square ? req.a : req.b;

    // ************************************************************************
    // pair p covers lanes 2p and 2p+1, its 2W-bit product lands exactly
    // on the bits of that pair, so products pack from the top down
    // ************************************************************************
    for (genvar w = 0; w < 3; w++) begin : g_width
        localparam int LW = `VEC_DATA_W / LANES[w];

        for (genvar p = 0; p < LANES[w] / 2; p++) begin : g_pair
            localparam int PH = `VEC_DATA_W - 1 - p * 2 * LW;   // pair msb

            logic [LW-1:0] x;
            logic [LW-1:0] y;

            // even lane is the upper one of the pair
            assign x = odd ? req.a[PH-LW -: LW] : req.a[PH -: LW];
            assign y = odd ? factor_b[PH-LW -: LW] : factor_b[PH -: LW];

            assign prod_res[w][PH -: 2*LW] = (2*LW)'(x) * (2*LW)'(y);
        end
    end

    // no room for a 128-bit product
    always_comb begin
        case (req.width)
            vec_alu_pkg::LW_BYTE: begin
                product = prod_res[0];
            end
            vec_alu_pkg::LW_HALF: begin
                product = prod_res[1];
            end
            vec_alu_pkg::LW_WORD: begin
                product = prod_res[2];
            end
            default: begin
                product = '0;
            end
        endcase
    end

endmodule

//--- hw/result_select.sv
`include "vec_alu_consts.svh"

module result_select (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alu,        // issue strobe
    input  vec_alu_pkg::alu_req_t  req,
    input  vec_alu_pkg::vec_word_t sum,
    input  vec_alu_pkg::vec_word_t shifted,
    input  vec_alu_pkg::vec_word_t product,
    output vec_alu_pkg::vec_word_t alu_out,
    output logic                   out_valid
);

    logic [`VEC_DATA_W-1:0] logic_res;    // bitwise, move and store
    logic [`VEC_DATA_W-1:0] result;

    // ************************************************************************
    // width independent ops, done right here
    // ************************************************************************
    always_comb begin
        case (req.op)
            vec_alu_pkg::OP_VAND: logic_res = req.a & req.b;
            vec_alu_pkg::OP_VOR:  logic_res = req.a | req.b;
            vec_alu_pkg::OP_VXOR: logic_res = req.a ^ req.b;
            vec_alu_pkg::OP_VNOT: logic_res = ~req.a;
            vec_alu_pkg::OP_VMOV: logic_res = req.a;
            vec_alu_pkg::OP_VSD:  logic_res = req.b;     // store data path
            default:              logic_res = '0;
        endcase
    end

    // ************************************************************************
    // class select, each unit already resolved its own variant
    // ************************************************************************
    always_comb begin
        case (req.op)
            vec_alu_pkg::OP_VAND,
            vec_alu_pkg::OP_VOR,
            vec_alu_pkg::OP_VXOR,
            vec_alu_pkg::OP_VNOT,
            vec_alu_pkg::OP_VMOV,
            vec_alu_pkg::OP_VSD: begin
                result = logic_res;
            end
            vec_alu_pkg::OP_VADD,
            vec_alu_pkg::OP_VSUB: begin
                result = sum;
            end
            vec_alu_pkg::OP_VSLL,
            vec_alu_pkg::OP_VSRL,
            vec_alu_pkg::OP_VSRA,
            vec_alu_pkg::OP_VRTTH: begin
                result = shifted;
            end
            vec_alu_pkg::OP_VMULEU,
            vec_alu_pkg::OP_VMULOU,
            vec_alu_pkg::OP_VSQEU,
            vec_alu_pkg::OP_VSQOU: begin
                result = product;
            end
            default: begin
                result = '0;                          // nop and unused codes
            end
        endcase
    end

    // execute stage register, result and valid appear on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_out   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= alu;                         // one pulse per issue
            if (alu) begin
                alu_out <= result;                    // hold while idle
            end
        end
    end

endmodule

//--- hw/vec_alu_top.sv
module vec_alu_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alu,          // issue strobe
    input  vec_alu_pkg::alu_op_t      alu_op,
    input  vec_alu_pkg::lane_width_t  width,        // no effect on bitwise ops
    input  vec_alu_pkg::vec_word_t    reg_a_data,
    input  vec_alu_pkg::vec_word_t    reg_b_data,
    output vec_alu_pkg::vec_word_t    alu_out,
    output logic                      out_valid
);

    vec_alu_pkg::alu_req_t  req;

    vec_alu_pkg::vec_word_t sum;
    vec_alu_pkg::vec_word_t shifted;
    vec_alu_pkg::vec_word_t product;

    // one bundle fanned out to every unit
    assign req = '{
        op:    alu_op,
        width: width,
        a:     reg_a_data,
        b:     reg_b_data
    };

    // ************************************************************************
    // lane units, all combinational
    // ************************************************************************
    lane_add_sub u_add_sub (
        .req     (req),
        .sum     (sum)
    );

    lane_shift_rotate u_shift_rotate (
        .req     (req),
        .shifted (shifted)
    );

    lane_multiply u_multiply (
        .req     (req),
        .product (product)
    );

    // final mux and the output register
    result_select u_result_select (
        .clk       (clk),
        .rst       (rst),
        .alu       (alu),
        .req       (req),
        .sum       (sum),
        .shifted   (shifted),
        .product   (product),
        .alu_out   (alu_out),
        .out_valid (out_valid)
    );

endmodule

//--- test/vec_alu_tb.sv
`include "vec_alu_consts.svh"

module vec_alu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // opcode pools per class, bitwise pool carries unused codes too
    localparam logic [5:0] BIT_OPS [12] = '{
        `VEC_OP_VAND, `VEC_OP_VOR, `VEC_OP_VXOR, `VEC_OP_VNOT, `VEC_OP_VMOV, `VEC_OP_VSD,
        `VEC_OP_VNOP, 6'd0, 6'd14, 6'd18, 6'd22, 6'd63
    };
    localparam logic [5:0] ARITH_OPS [2] = '{`VEC_OP_VADD, `VEC_OP_VSUB};
    localparam logic [5:0] SHIFT_OPS [4] = '{
        `VEC_OP_VSLL, `VEC_OP_VSRL, `VEC_OP_VSRA, `VEC_OP_VRTTH
    };
    localparam logic [5:0] MUL_OPS [4] = '{
        `VEC_OP_VMULEU, `VEC_OP_VMULOU, `VEC_OP_VSQEU, `VEC_OP_VSQOU
    };

    logic                     clk;
    logic                     rst;
    logic                     alu;
    vec_alu_pkg::alu_op_t     alu_op;
    vec_alu_pkg::lane_width_t width;
    vec_alu_pkg::vec_word_t   reg_a_data;
    vec_alu_pkg::vec_word_t   reg_b_data;
    vec_alu_pkg::vec_word_t   alu_out;
    logic                     out_valid;

    logic [63:0] expected_q [$];   // model results in issue order
    logic [63:0] expected;
    logic [63:0] held;             // last value alu_out must keep
    logic        valid_due;
    int          issued;
    int          checks;
    int          value_errors;
    int          other_errors;

    vec_alu_top DUT (
        .clk        (clk),
        .rst        (rst),
        .alu        (alu),
        .alu_op     (alu_op),
        .width      (width),
        .reg_a_data (reg_a_data),
        .reg_b_data (reg_b_data),
        .alu_out    (alu_out),
        .out_valid  (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ************************************************************************
    // reference model, lane 0 at the most significant end
    // ************************************************************************
    function automatic logic [63:0] lane_mask(input int lw);
        lane_mask = {64{1'b1}} >> (64 - lw);
    endfunction

    function automatic logic [63:0] lane_of(input logic [63:0] v, input int i, input int lw);
        lane_of = (v >> (64 - (i + 1) * lw)) & lane_mask(lw);
    endfunction

    function automatic logic [63:0] model_result(input logic [5:0] op, input logic [1:0] w,
                                                 input logic [63:0] a, input logic [63:0] b);
        int          lw;
        int          nl;
        int          amt;
        int          src;
        int          i;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        logic [63:0] res;
        lw   = 8 << w;
        nl   = 64 / lw;
        mask = lane_mask(lw);
        res  = '0;
        case (op)
            `VEC_OP_VAND: res = a & b;
            `VEC_OP_VOR:  res = a | b;
            `VEC_OP_VXOR: res = a ^ b;
            `VEC_OP_VNOT: res = ~a;
            `VEC_OP_VMOV: res = a;
            `VEC_OP_VSD:  res = b;
            `VEC_OP_VADD, `VEC_OP_VSUB, `VEC_OP_VSLL, `VEC_OP_VSRL, `VEC_OP_VSRA,
            `VEC_OP_VRTTH: begin
                for (i = 0; i < nl; i++) begin
                    la  = lane_of(a, i, lw);
                    lb  = lane_of(b, i, lw);
                    amt = int'(lb[5:0]) & (lw - 1);     // log2(lw) low bits
                    case (op)
                        `VEC_OP_VADD: r = la + lb;
                        `VEC_OP_VSUB: r = la - lb;
                        `VEC_OP_VSLL: r = la << amt;
                        `VEC_OP_VSRL: r = la >> amt;
                        `VEC_OP_VSRA: begin
                            r = la >> amt;
                            if (((la >> (lw - 1)) & 64'd1) != 64'd0) begin
                                r = r | (mask & ~(mask >> amt));   // sign fill
                            end
                        end
                        default: r = (la << (lw / 2)) | (la >> (lw / 2));
                    endcase
                    res = res | ((r & mask) << (64 - (i + 1) * lw));
                end
            end
            `VEC_OP_VMULEU, `VEC_OP_VMULOU, `VEC_OP_VSQEU, `VEC_OP_VSQOU: begin
                if (lw < 64) begin
                    for (i = 0; i < nl / 2; i++) begin
                        src = 2 * i;
                        if (op == `VEC_OP_VMULOU || op == `VEC_OP_VSQOU) begin
                            src = src + 1;
                        end
                        la = lane_of(a, src, lw);
                        if (op == `VEC_OP_VSQEU || op == `VEC_OP_VSQOU) begin
                            lb = la;
                        end else begin
                            lb = lane_of(b, src, lw);
                        end
                        res = res | ((la * lb) << (64 - (i + 1) * 2 * lw));
                    end
                end
            end
            default: res = '0;
        endcase
        model_result = res;
    endfunction

    // ************************************************************************
    // stimulus
    // ************************************************************************
    function automatic logic [5:0] pick_op(input int cls);
        int c;
        c = (cls == 4) ? int'($urandom % 4) : cls;   // 4 mixes all classes
        case (c)
            0:       pick_op = BIT_OPS[4'($urandom % 12)];
            1:       pick_op = ARITH_OPS[1'($urandom)];
            2:       pick_op = SHIFT_OPS[2'($urandom)];
            default: pick_op = MUL_OPS[2'($urandom)];
        endcase
    endfunction

    task automatic issue(input logic [5:0] op, input logic [1:0] w,
                         input logic [63:0] a, input logic [63:0] b);
        @(posedge clk);
        alu        <= 1'b1;
        alu_op     <= vec_alu_pkg::alu_op_t'(op);
        width      <= vec_alu_pkg::lane_width_t'(w);
        reg_a_data <= a;
        reg_b_data <= b;
        expected_q.push_back(model_result(op, w, a, b));
        issued++;
    endtask

    // strobe low, other inputs keep moving
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            alu        <= 1'b0;
            alu_op     <= vec_alu_pkg::alu_op_t'(6'($urandom));
            width      <= vec_alu_pkg::lane_width_t'(2'($urandom));
            reg_a_data <= {$urandom, $urandom};
            reg_b_data <= {$urandom, $urandom};
        end
    endtask

    task automatic run_class(input int cls, input int w, input int count, input int max_gap);
        logic [1:0] wc;
        repeat (count) begin
            wc = (w < 0) ? 2'($urandom) : 2'(w);
            issue(pick_op(cls), wc, {$urandom, $urandom}, {$urandom, $urandom});
            idle(int'($urandom % (max_gap + 1)));
        end
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout: %0d results never came back after %0d cycles",
                     expected_q.size(), limit);
            other_errors++;
        end
    endtask

    // ************************************************************************
    // output checks, sampled away from the active edge
    // ************************************************************************
    always @(negedge clk) begin
        if (rst) begin
            held = '0;
        end else begin
            assert (out_valid == valid_due) else begin
                $display("** Error: out_valid expected %h got %h", valid_due, out_valid);
                value_errors++;
            end
            if (out_valid) begin
                assert (expected_q.size() != 0) else begin
                    $display("out_valid came with no operation pending");
                    other_errors++;
                end
                if (expected_q.size() != 0) begin
                    expected = expected_q.pop_front();
                    assert (alu_out == expected) else begin
                        $display("** Error: alu_out expected %h got %h", expected, alu_out);
                        value_errors++;
                    end
                    held = expected;
                end
            end else begin
                assert (alu_out == held) else begin   // idle hold
                    $display("** Error: alu_out expected %h got %h", held, alu_out);
                    value_errors++;
                end
            end
            checks++;
        end
        valid_due = alu;    // captured on the coming edge
    end

    initial begin
        int w;
        void'($urandom(76528));
        rst          = 1'b1;
        alu          = 1'b0;
        alu_op       = vec_alu_pkg::OP_VNOP;
        width        = vec_alu_pkg::LW_BYTE;
        reg_a_data   = '0;
        reg_b_data   = '0;
        valid_due    = 1'b0;
        held         = '0;
        issued       = 0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        idle(6);                        // zero output, no valid yet

        run_class(0, -1, 60, 2);        // bitwise, move, store, nop

        for (w = 0; w < 4; w++) begin
            issue(`VEC_OP_VADD, 2'(w), '1, '1);
            issue(`VEC_OP_VADD, 2'(w), 64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555);
            issue(`VEC_OP_VADD, 2'(w), 64'h8080_8080_8080_8080, 64'h8080_8080_8080_8080);
            issue(`VEC_OP_VSUB, 2'(w), '0, 64'h0101_0101_0101_0101);
            issue(`VEC_OP_VSUB, 2'(w), '0, '1);
            run_class(1, w, 40, 1);
        end

        for (w = 0; w < 4; w++) begin
            issue(`VEC_OP_VSRA, 2'(w), 64'hF0E1_D2C3_B4A5_9687, {$urandom, $urandom});
            issue(`VEC_OP_VSRA, 2'(w), 64'h8080_8080_8080_8080, {$urandom, $urandom});
            run_class(2, w, 40, 1);
        end

        for (w = 0; w < 4; w++) begin
            run_class(3, w, 30, 1);     // double width gives zero
        end

        // back to back stream, then a gap stream
        run_class(4, -1, 80, 0);
        idle(5);
        run_class(4, -1, 40, 3);

        idle(1);
        wait_drain(20);
        idle(2);

        $display("issued %0d, checked %0d cycles, value errors %0d, other errors %0d",
                 issued, checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+hw
hw/vec_alu_pkg.sv
hw/lane_add_sub.sv
hw/lane_shift_rotate.sv
hw/lane_multiply.sv
hw/result_select.sv
hw/vec_alu_top.sv
test/vec_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vector ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module vec_alu_tb \
    -o vec_alu_sim

./obj_dir/vec_alu_sim > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
